/* hw/atop_pkg.sv */
// Shared definitions for the atomic-operation filter subsystem.
// Holds the bus widths, the atop and response encodings and the AXI4
// channel structs with their request and response bundles.
package atop_pkg;

  // Bus widths.
  localparam int unsigned ID_W   = 4;
  localparam int unsigned ADDR_W = 16;
  localparam int unsigned DATA_W = 32;
  localparam int unsigned STRB_W = DATA_W / 8;

  // Number of write bursts that may be in flight towards the memory.
  localparam int unsigned MAX_WRITE_TXNS = 2;

  // Memory depth in words and the width of a word index.
  localparam int unsigned MEM_WORDS  = 256;
  localparam int unsigned WORD_IDX_W = $clog2(MEM_WORDS);

  // Atomic kind, taken from atop bits 5:4.
  localparam logic [1:0] ATOP_NONE        = 2'b00;
  localparam logic [1:0] ATOP_ATOMICSTORE = 2'b01;

  // Response codes.
  localparam logic [1:0] RESP_OKAY   = 2'b00;
  localparam logic [1:0] RESP_SLVERR = 2'b10;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
    logic [5:0]        atop;
  } aw_chan_t;

  typedef struct packed {
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic              last;
  } w_chan_t;

  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [1:0]      resp;
  } b_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [ADDR_W-1:0] addr;
    logic [7:0]        len;
  } ar_chan_t;

  typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] data;
    logic [1:0]        resp;
    logic              last;
  } r_chan_t;

  // Everything the master drives.
  typedef struct packed {
    aw_chan_t aw;
    logic     aw_valid;
    w_chan_t  w;
    logic     w_valid;
    logic     b_ready;
    ar_chan_t ar;
    logic     ar_valid;
    logic     r_ready;
  } axi_req_t;

  // Everything the slave drives.
  typedef struct packed {
    logic     aw_ready;
    logic     w_ready;
    b_chan_t  b;
    logic     b_valid;
    logic     ar_ready;
    r_chan_t  r;
    logic     r_valid;
  } axi_resp_t;

  // Request for an injected R burst of len+1 error beats.
  typedef struct packed {
    logic [ID_W-1:0] id;
    logic [7:0]      len;
  } r_inject_cmd_t;

endpackage

/* hw/stream_register.sv */
// One-entry valid/ready register.
// The payload type is a parameter so that one block serves several streams.
`timescale 1ns/1ps

module stream_register #(
  parameter type T = logic
) (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic valid_i,
  output logic ready_o,
  input  T     data_i,
  output logic valid_o,
  input  logic ready_i,
  output T     data_o
);

  logic valid_q;
  T     data_q;

  // The slot accepts a new item when it is empty or drains in this cycle.
  assign ready_o = !valid_q || ready_i;
  assign valid_o = valid_q;
  assign data_o  = data_q;

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= 1'b0;
    end else if (valid_i && ready_o) begin
      valid_q <= 1'b1;
    end else if (ready_i) begin
      valid_q <= 1'b0;
    end
  end

  // The payload only changes when a new item is taken in.
  always_ff @(posedge clk_i) begin
    if (valid_i && ready_o) begin
      data_q <= data_i;
    end
  end

  // A held item must not change before the consumer takes it.
  a_data_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
    valid_o && !ready_i |=> valid_o && $stable(data_o));

endmodule

/* hw/atop_write_ctrl.sv */
// Write-path controller of the atomic-operation filter.
// Feeds ordinary AW/W/B traffic to the memory, absorbs atomic writes,
// answers them with an injected SLVERR B and requests the matching R burst.
`timescale 1ns/1ps

module atop_write_ctrl (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  atop_pkg::aw_chan_t      slv_aw_i,
  input  logic                    slv_aw_valid_i,
  output logic                    slv_aw_ready_o,
  input  atop_pkg::w_chan_t       slv_w_i,
  input  logic                    slv_w_valid_i,
  output logic                    slv_w_ready_o,
  output atop_pkg::b_chan_t       slv_b_o,
  output logic                    slv_b_valid_o,
  input  logic                    slv_b_ready_i,
  output logic                    mem_aw_valid_o,
  input  logic                    mem_aw_ready_i,
  output logic                    mem_w_valid_o,
  input  logic                    mem_w_ready_i,
  input  atop_pkg::b_chan_t       mem_b_i,
  input  logic                    mem_b_valid_i,
  output logic                    mem_b_ready_o,
  output atop_pkg::r_inject_cmd_t r_cmd_o,
  output logic                    r_cmd_valid_o,
  input  logic                    r_busy_i
);

  typedef enum logic [2:0] {W_FEEDTHROUGH, BLOCK_AW, ABSORB_W, INJECT_B, WAIT_R} w_state_t;
  typedef logic [$clog2(atop_pkg::MAX_WRITE_TXNS+1)-1:0] cnt_t;

  w_state_t                  state_d, state_q;
  cnt_t                      cnt_d, cnt_q;
  logic [atop_pkg::ID_W-1:0] id_d, id_q;
  logic                      aw_is_atop;

  assign aw_is_atop = slv_aw_i.atop[5:4] != atop_pkg::ATOP_NONE;

  // The R command always describes the AW currently on the slave port.
  assign r_cmd_o = '{id: slv_aw_i.id, len: slv_aw_i.len};

  always_comb begin
    mem_aw_valid_o = 1'b0;
    slv_aw_ready_o = 1'b0;
    mem_w_valid_o  = 1'b0;
    slv_w_ready_o  = 1'b0;
    // Memory B responses pass through unless an injection takes the channel.
    mem_b_ready_o  = slv_b_ready_i;
    slv_b_valid_o  = mem_b_valid_i;
    slv_b_o        = mem_b_i;
    r_cmd_valid_o  = 1'b0;
    id_d           = id_q;
    state_d        = state_q;
    case (state_q)
      W_FEEDTHROUGH: begin
        // New bursts go downstream only while the in-flight limit allows it.
        if (cnt_q < cnt_t'(atop_pkg::MAX_WRITE_TXNS)) begin
          mem_aw_valid_o = slv_aw_valid_i;
          slv_aw_ready_o = mem_aw_ready_i;
        end
        // W beats need a known AW ahead of them, so they wait for one.
        if (cnt_q != '0) begin
          mem_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mem_w_ready_i;
        end
        if (slv_aw_valid_i && aw_is_atop) begin
          // The atomic AW is swallowed here and its ID kept for the replies.
          mem_aw_valid_o = 1'b0;
          slv_aw_ready_o = 1'b1;
          id_d           = slv_aw_i.id;
          // The register is empty here, since WAIT_R drained it before.
          r_cmd_valid_o  = slv_aw_i.atop[5:4] != atop_pkg::ATOP_ATOMICSTORE;
          if (cnt_q != '0) begin
            state_d = BLOCK_AW;
          end else begin
            mem_w_valid_o = 1'b0;
            slv_w_ready_o = 1'b1;
            state_d = (slv_w_valid_i && slv_w_i.last) ? INJECT_B : ABSORB_W;
          end
        end
      end
      BLOCK_AW: begin
        // Earlier bursts finish their W beats before the atomic data is absorbed.
        if (cnt_q != '0) begin
          mem_w_valid_o = slv_w_valid_i;
          slv_w_ready_o = mem_w_ready_i;
        end else begin
          slv_w_ready_o = 1'b1;
          state_d = (slv_w_valid_i && slv_w_i.last) ? INJECT_B : ABSORB_W;
        end
      end
      ABSORB_W: begin
        slv_w_ready_o = 1'b1;
        if (slv_w_valid_i && slv_w_i.last) begin
          state_d = INJECT_B;
        end
      end
      INJECT_B: begin
        // A memory B already on the port is delivered first so that it is not
        // replaced before its handshake.
        if (!mem_b_valid_i) begin
          slv_b_o       = '{id: id_q, resp: atop_pkg::RESP_SLVERR};
          slv_b_valid_o = 1'b1;
          if (slv_b_ready_i) begin
            state_d = r_busy_i ? WAIT_R : W_FEEDTHROUGH;
          end
        end
      end
      WAIT_R: begin
        // The next atomic write must find the R command register empty.
        if (!r_busy_i) begin
          state_d = W_FEEDTHROUGH;
        end
      end
      default: state_d = W_FEEDTHROUGH;
    endcase
  end

  // Count bursts whose AW went downstream but whose last W has not.
  always_comb begin
    cnt_d = cnt_q;
    if (mem_aw_valid_o && mem_aw_ready_i) begin
      cnt_d = cnt_d + cnt_t'(1);
    end
    if (mem_w_valid_o && mem_w_ready_i && slv_w_i.last) begin
      cnt_d = cnt_d - cnt_t'(1);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= W_FEEDTHROUGH;
      cnt_q   <= '0;
      id_q    <= '0;
    end else begin
      state_q <= state_d;
      cnt_q   <= cnt_d;
      id_q    <= id_d;
    end
  end

  // Whichever source drives B, a raised valid holds until the master takes it.
  a_b_valid_held: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slv_b_valid_o && !slv_b_ready_i |=> slv_b_valid_o);

endmodule

/* hw/atop_read_inject.sv */
// R-channel injector of the atomic-operation filter.
// Passes memory read data through and, for each queued command, sends a
// burst of SLVERR beats with the atomic write's ID.
`timescale 1ns/1ps

module atop_read_inject (
  input  logic                    clk_i,
  input  logic                    rst_ni,
  input  atop_pkg::r_inject_cmd_t r_cmd_i,
  input  logic                    r_cmd_valid_i,
  output logic                    r_busy_o,
  input  atop_pkg::r_chan_t       mem_r_i,
  input  logic                    mem_r_valid_i,
  output logic                    mem_r_ready_o,
  output atop_pkg::r_chan_t       slv_r_o,
  output logic                    slv_r_valid_o,
  input  logic                    slv_r_ready_i
);

  typedef enum logic {R_FEEDTHROUGH, INJECT_R} r_state_t;

  r_state_t                r_state_d, r_state_q;
  logic [7:0]              beats_d, beats_q;
  atop_pkg::r_inject_cmd_t cmd;
  logic                    cmd_valid, cmd_ready, cmd_pop;

  stream_register #(
    .T (atop_pkg::r_inject_cmd_t)
  ) i_cmd_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (r_cmd_valid_i),
    .ready_o (cmd_ready),
    .data_i  (r_cmd_i),
    .valid_o (cmd_valid),
    .ready_i (cmd_pop),
    .data_o  (cmd)
  );

  // The command stays held until its final beat is taken.
  assign r_busy_o = cmd_valid;

  always_comb begin
    slv_r_o       = mem_r_i;
    slv_r_valid_o = mem_r_valid_i;
    mem_r_ready_o = slv_r_ready_i;
    cmd_pop       = 1'b0;
    beats_d       = beats_q;
    r_state_d     = r_state_q;
    case (r_state_q)
      R_FEEDTHROUGH: begin
        // Switch only when no memory beat is left waiting on the port.
        if (cmd_valid && !(mem_r_valid_i && !slv_r_ready_i)) begin
          beats_d   = cmd.len;
          r_state_d = INJECT_R;
        end
      end
      INJECT_R: begin
        // The memory R channel is paused for the whole injected burst.
        mem_r_ready_o = 1'b0;
        slv_r_o       = '{id: cmd.id, data: '0, resp: atop_pkg::RESP_SLVERR,
                          last: beats_q == '0};
        slv_r_valid_o = 1'b1;
        if (slv_r_ready_i) begin
          if (beats_q == '0) begin
            cmd_pop   = 1'b1;
            r_state_d = R_FEEDTHROUGH;
          end else begin
            beats_d = beats_q - 8'd1;
          end
        end
      end
      default: r_state_d = R_FEEDTHROUGH;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      r_state_q <= R_FEEDTHROUGH;
      beats_q   <= '0;
    end else begin
      r_state_q <= r_state_d;
      beats_q   <= beats_d;
    end
  end

  // The write controller pushes a command only into an empty register.
  a_push_empty: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_cmd_valid_i |-> cmd_ready);

  // The remaining beat count never exceeds the burst length of the held
  // command, so it cannot wrap below zero.
  a_no_underflow: assert property (@(posedge clk_i) disable iff (!rst_ni)
    r_state_q == INJECT_R |-> beats_q <= cmd.len);

endmodule

/* hw/axi_burst_mem.sv */
// AXI4 word memory for INCR bursts, without atomic support.
// Serves one write burst and one read burst at a time and answers OKAY.
`timescale 1ns/1ps

module axi_burst_mem (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::axi_req_t  req_i,
  output atop_pkg::axi_resp_t resp_o
);

  logic [atop_pkg::DATA_W-1:0]     mem_q [atop_pkg::MEM_WORDS];
  logic                            wr_active_q, rd_active_q;
  logic [atop_pkg::WORD_IDX_W-1:0] wr_ptr_q, rd_ptr_q;
  logic [atop_pkg::ID_W-1:0]       wr_id_q, rd_id_q;
  logic [7:0]                      rd_beats_q;
  logic                            aw_hs, w_hs, ar_hs, r_hs;
  logic                            b_push_ready;
  atop_pkg::b_chan_t               b_push;

  // Ready follows valid, so it stays low while the master is idle.
  assign resp_o.aw_ready = req_i.aw_valid && !wr_active_q;
  // A last beat is accepted only if its B response has a free slot.
  assign resp_o.w_ready  = wr_active_q && b_push_ready;
  assign resp_o.ar_ready = req_i.ar_valid && !rd_active_q;

  assign aw_hs = req_i.aw_valid && resp_o.aw_ready;
  assign w_hs  = req_i.w_valid && resp_o.w_ready;
  assign ar_hs = req_i.ar_valid && resp_o.ar_ready;
  assign r_hs  = resp_o.r_valid && req_i.r_ready;

  assign b_push = '{id: wr_id_q, resp: atop_pkg::RESP_OKAY};

  // B leaves through this register one cycle after the last W beat.
  stream_register #(
    .T (atop_pkg::b_chan_t)
  ) i_b_reg (
    .clk_i   (clk_i),
    .rst_ni  (rst_ni),
    .valid_i (w_hs && req_i.w.last),
    .ready_o (b_push_ready),
    .data_i  (b_push),
    .valid_o (resp_o.b_valid),
    .ready_i (req_i.b_ready),
    .data_o  (resp_o.b)
  );

  // Read data comes straight from the array at the current read pointer.
  assign resp_o.r_valid = rd_active_q;
  assign resp_o.r       = '{id: rd_id_q, data: mem_q[rd_ptr_q],
                            resp: atop_pkg::RESP_OKAY, last: rd_beats_q == '0};

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      wr_active_q <= 1'b0;
      wr_ptr_q    <= '0;
      wr_id_q     <= '0;
      rd_active_q <= 1'b0;
      rd_ptr_q    <= '0;
      rd_id_q     <= '0;
      rd_beats_q  <= '0;
    end else begin
      if (aw_hs) begin
        wr_active_q <= 1'b1;
        wr_ptr_q    <= req_i.aw.addr[atop_pkg::WORD_IDX_W+1:2];
        wr_id_q     <= req_i.aw.id;
      end else if (w_hs) begin
        // The pointer wraps within the array at its natural width.
        wr_ptr_q <= wr_ptr_q + 1'b1;
        if (req_i.w.last) begin
          wr_active_q <= 1'b0;
        end
      end
      if (ar_hs) begin
        rd_active_q <= 1'b1;
        rd_ptr_q    <= req_i.ar.addr[atop_pkg::WORD_IDX_W+1:2];
        rd_id_q     <= req_i.ar.id;
        rd_beats_q  <= req_i.ar.len;
      end else if (r_hs) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
        if (rd_beats_q == '0) begin
          rd_active_q <= 1'b0;
        end else begin
          rd_beats_q <= rd_beats_q - 8'd1;
        end
      end
    end
  end

  // Only the strobed bytes of each accepted beat are written.
  always_ff @(posedge clk_i) begin
    if (w_hs) begin
      for (int b = 0; b < atop_pkg::STRB_W; b++) begin
        if (req_i.w.strb[b]) begin
          mem_q[wr_ptr_q][8*b +: 8] <= req_i.w.data[8*b +: 8];
        end
      end
    end
  end

  // The filter in front must never let an atomic AW reach this memory.
  a_no_atop: assert property (@(posedge clk_i) disable iff (!rst_ni)
    req_i.aw_valid |-> req_i.aw.atop == '0);

endmodule

/* hw/atop_filter_top.sv */
// Top level of the atomic-operation filter subsystem.
// Wires the write controller and the R injector in front of the burst memory.
`timescale 1ns/1ps

module atop_filter_top (
  input  logic                clk_i,
  input  logic                rst_ni,
  input  atop_pkg::axi_req_t  slv_req_i,
  output atop_pkg::axi_resp_t slv_resp_o
);

  atop_pkg::axi_req_t      mem_req;
  atop_pkg::axi_resp_t     mem_resp;
  atop_pkg::r_inject_cmd_t r_cmd;
  atop_pkg::b_chan_t       slv_b;
  atop_pkg::r_chan_t       slv_r;
  logic                    r_cmd_valid, r_busy;
  logic                    slv_aw_ready, slv_w_ready, slv_b_valid, slv_r_valid;
  logic                    mem_aw_valid, mem_w_valid, mem_b_ready, mem_r_ready;

  atop_write_ctrl i_write_ctrl (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .slv_aw_i       (slv_req_i.aw),
    .slv_aw_valid_i (slv_req_i.aw_valid),
    .slv_aw_ready_o (slv_aw_ready),
    .slv_w_i        (slv_req_i.w),
    .slv_w_valid_i  (slv_req_i.w_valid),
    .slv_w_ready_o  (slv_w_ready),
    .slv_b_o        (slv_b),
    .slv_b_valid_o  (slv_b_valid),
    .slv_b_ready_i  (slv_req_i.b_ready),
    .mem_aw_valid_o (mem_aw_valid),
    .mem_aw_ready_i (mem_resp.aw_ready),
    .mem_w_valid_o  (mem_w_valid),
    .mem_w_ready_i  (mem_resp.w_ready),
    .mem_b_i        (mem_resp.b),
    .mem_b_valid_i  (mem_resp.b_valid),
    .mem_b_ready_o  (mem_b_ready),
    .r_cmd_o        (r_cmd),
    .r_cmd_valid_o  (r_cmd_valid),
    .r_busy_i       (r_busy)
  );

  atop_read_inject i_read_inject (
    .clk_i         (clk_i),
    .rst_ni        (rst_ni),
    .r_cmd_i       (r_cmd),
    .r_cmd_valid_i (r_cmd_valid),
    .r_busy_o      (r_busy),
    .mem_r_i       (mem_resp.r),
    .mem_r_valid_i (mem_resp.r_valid),
    .mem_r_ready_o (mem_r_ready),
    .slv_r_o       (slv_r),
    .slv_r_valid_o (slv_r_valid),
    .slv_r_ready_i (slv_req_i.r_ready)
  );

  // The memory sees the master's payloads with atop cleared and AR untouched.
  always_comb begin
    mem_req          = slv_req_i;
    mem_req.aw.atop  = '0;
    mem_req.aw_valid = mem_aw_valid;
    mem_req.w_valid  = mem_w_valid;
    mem_req.b_ready  = mem_b_ready;
    mem_req.r_ready  = mem_r_ready;
  end

  // AR ready comes from the memory, everything else from the two controllers.
  always_comb begin
    slv_resp_o          = mem_resp;
    slv_resp_o.aw_ready = slv_aw_ready;
    slv_resp_o.w_ready  = slv_w_ready;
    slv_resp_o.b        = slv_b;
    slv_resp_o.b_valid  = slv_b_valid;
    slv_resp_o.r        = slv_r;
    slv_resp_o.r_valid  = slv_r_valid;
  end

  axi_burst_mem i_mem (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .req_i  (mem_req),
    .resp_o (mem_resp)
  );

endmodule

/* include/tb_checks.svh */
// Compare tasks for the atomic-filter testbench.
// Each check reports a mismatch with time, signal and both values, then stops.
`ifndef TB_CHECKS_SVH
`define TB_CHECKS_SVH

// Prints the failure, the summary line and ends the run.
task automatic report_fail(input string sig, input string act, input string exp);
  $display("[FAIL] %0t %s: got %s, expected %s", $time, sig, act, exp);
  $display("CHECKS FAILED");
  $fatal(1, "Mismatch on %s", sig);
endtask

// Compares a B beat field by field.
task automatic check_b(input string sig,
                       input atop_pkg::b_chan_t act,
                       input atop_pkg::b_chan_t exp);
  if (act !== exp) begin
    report_fail(sig,
                $sformatf("id=%0h resp=%0d", act.id, act.resp),
                $sformatf("id=%0h resp=%0d", exp.id, exp.resp));
  end
endtask

// Compares an R beat, data and last included.
task automatic check_r(input string sig,
                       input atop_pkg::r_chan_t act,
                       input atop_pkg::r_chan_t exp);
  if (act !== exp) begin
    report_fail(sig,
                $sformatf("id=%0h data=%08h resp=%0d last=%0b",
                          act.id, act.data, act.resp, act.last),
                $sformatf("id=%0h data=%08h resp=%0d last=%0b",
                          exp.id, exp.data, exp.resp, exp.last));
  end
endtask

`endif

/* verification/tb_atop_filter.sv */
// Testbench for the atomic-operation filter subsystem.
// Replays transactions from a case file as one AXI4 master and checks every
// B and R beat against a word model of the memory behind the filter.
`timescale 1ns/1ps

module tb_atop_filter;

  localparam string CASE_FILE = "verification/atop_cases.txt";
  localparam int    MAX_CASES = 64;
  localparam int    CH_AW     = 0;
  localparam int    CH_W      = 1;
  localparam int    CH_AR     = 2;

  logic                clk_i;
  logic                rst_ni;
  atop_pkg::axi_req_t  slv_req;
  atop_pkg::axi_resp_t slv_resp;

  // Case word layout is op[39:36], id[35:32], addr[31:16], len[15:8], atop[7:0].
  logic [39:0]                 cases [MAX_CASES];
  logic [atop_pkg::DATA_W-1:0] model [atop_pkg::MEM_WORDS];
  atop_pkg::b_chan_t           b_q [$];
  atop_pkg::r_chan_t           r_q [$];
  integer                      seed;
  int                          n_cases;
  int                          cycle_limit;
  int                          cycle_cnt;

  `include "tb_checks.svh"

  atop_filter_top dut (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .slv_req_i  (slv_req),
    .slv_resp_o (slv_resp)
  );

  initial begin
    clk_i = 1'b0;
    forever #20 clk_i = ~clk_i;
  end

  // Ends the run for a failure that is not a wrong value.
  task automatic abort_run(input string why);
    $display("Error at %0t: %s", $time, why);
    $display("CHECKS FAILED");
    $fatal(1, "%s", why);
  endtask

  // Moves to just after the next rising edge and redraws the back-pressure.
  task automatic next_cycle();
    @(posedge clk_i);
    #2;
    slv_req.b_ready = ($random(seed) & 3) != 0;
    slv_req.r_ready = ($random(seed) & 3) != 0;
  endtask

  // Holds the current beat until the DUT takes it on a rising edge.
  task automatic wait_accept(input int chan);
    logic accepted;
    accepted = 1'b0;
    while (!accepted) begin
      @(negedge clk_i);
      case (chan)
        CH_AW:   accepted = slv_resp.aw_ready;
        CH_W:    accepted = slv_resp.w_ready;
        default: accepted = slv_resp.ar_ready;
      endcase
      next_cycle();
    end
  endtask

  // Waits until the monitor has collected enough responses. The watchdog
  // catches responses that never come.
  task automatic await_responses(input int nb, input int nr);
    while (b_q.size() < nb || r_q.size() < nr) begin
      next_cycle();
    end
  endtask

  task automatic do_write(input logic [3:0] id, input logic [15:0] addr,
                          input logic [7:0] len, input logic [5:0] atop);
    atop_pkg::b_chan_t exp_b;
    atop_pkg::r_chan_t exp_r;
    logic              atomic;
    logic              want_r;
    int                i;
    // Any non-zero kind is atomic. Only atomic store has no read data.
    atomic = atop[5:4] != 2'b00;
    want_r = atomic && atop[5:4] != 2'b01;
    slv_req.aw.id   = id;
    slv_req.aw.addr = addr;
    slv_req.aw.len  = len;
    slv_req.aw.atop = atop;
    slv_req.aw_valid = 1'b1;
    wait_accept(CH_AW);
    slv_req.aw_valid = 1'b0;
    for (i = 0; i <= len; i++) begin
      slv_req.w.data  = $random(seed);
      slv_req.w.strb  = '1;
      slv_req.w.last  = i == len;
      slv_req.w_valid = 1'b1;
      // Atomic data must never land in memory, so the model skips it.
      if (!atomic) begin
        model[(int'(addr >> 2) + i) % atop_pkg::MEM_WORDS] = slv_req.w.data;
      end
      wait_accept(CH_W);
    end
    slv_req.w_valid = 1'b0;
    await_responses(1, want_r ? int'(len) + 1 : 0);
    exp_b.id   = id;
    exp_b.resp = atomic ? atop_pkg::RESP_SLVERR : atop_pkg::RESP_OKAY;
    check_b("slv_resp.b", b_q.pop_front(), exp_b);
    if (want_r) begin
      for (i = 0; i <= len; i++) begin
        exp_r.id   = id;
        exp_r.data = '0;
        exp_r.resp = atop_pkg::RESP_SLVERR;
        exp_r.last = i == len;
        check_r("slv_resp.r", r_q.pop_front(), exp_r);
      end
    end
    if (r_q.size() != 0 || b_q.size() != 0) begin
      abort_run($sformatf("write id %0h got more responses than it should", id));
    end
  endtask

  task automatic do_read(input logic [3:0] id, input logic [15:0] addr,
                         input logic [7:0] len);
    atop_pkg::r_chan_t exp_r;
    int                i;
    slv_req.ar.id   = id;
    slv_req.ar.addr = addr;
    slv_req.ar.len  = len;
    slv_req.ar_valid = 1'b1;
    wait_accept(CH_AR);
    slv_req.ar_valid = 1'b0;
    await_responses(0, int'(len) + 1);
    for (i = 0; i <= len; i++) begin
      exp_r.id   = id;
      exp_r.data = model[(int'(addr >> 2) + i) % atop_pkg::MEM_WORDS];
      exp_r.resp = atop_pkg::RESP_OKAY;
      exp_r.last = i == len;
      check_r("slv_resp.r", r_q.pop_front(), exp_r);
    end
    if (r_q.size() != 0 || b_q.size() != 0) begin
      abort_run($sformatf("read id %0h got more responses than it should", id));
    end
  endtask

  // Loads the case file. Counting stops at the first entry that is not a
  // read or a write.
  task automatic load_cases();
    int fd;
    int i;
    fd = $fopen(CASE_FILE, "r");
    if (fd == 0) begin
      abort_run($sformatf("cannot open the case file %s", CASE_FILE));
    end
    $fclose(fd);
    for (i = 0; i < MAX_CASES; i++) begin
      cases[i] = '0;
    end
    $readmemh(CASE_FILE, cases);
    n_cases = 0;
    while (n_cases < MAX_CASES &&
           (cases[n_cases][39:36] == 4'd1 || cases[n_cases][39:36] == 4'd2)) begin
      n_cases++;
    end
    if (n_cases == 0) begin
      abort_run("the case file holds no transactions");
    end
    cycle_limit = n_cases * 64;
  endtask

  // The monitor samples mid-cycle, where valid and ready are settled.
  always @(negedge clk_i) begin
    if (rst_ni && slv_resp.b_valid && slv_req.b_ready) begin
      b_q.push_back(slv_resp.b);
    end
    if (rst_ni && slv_resp.r_valid && slv_req.r_ready) begin
      r_q.push_back(slv_resp.r);
    end
  end

  initial begin : watchdog
    wait (cycle_limit != 0);
    while (cycle_cnt < cycle_limit) begin
      @(posedge clk_i);
      cycle_cnt++;
    end
    abort_run($sformatf("timeout, the run did not finish in %0d cycles", cycle_limit));
  end

  initial begin : main
    int i;
    slv_req     = '0;
    rst_ni      = 1'b0;
    seed        = 32'hbe636c3f;
    cycle_cnt   = 0;
    cycle_limit = 0;
    load_cases();
    repeat (4) @(posedge clk_i);
    #2;
    rst_ni = 1'b1;
    for (i = 0; i < n_cases; i++) begin
      if (cases[i][39:36] == 4'd1) begin
        do_write(cases[i][35:32], cases[i][31:16], cases[i][15:8], cases[i][5:0]);
      end else begin
        do_read(cases[i][35:32], cases[i][31:16], cases[i][15:8]);
      end
    end
    // Late responses would show up here.
    repeat (8) next_cycle();
    if (b_q.size() != 0 || r_q.size() != 0) begin
      abort_run("responses arrived after the last transaction had finished");
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

/* verification/atop_cases.txt */
// One transaction per line: op (1 write, 2 read) _ id _ byte address _ len _ atop.
// atop bits 5:4 give the kind: 0 none, 1 atomic store, 2 atomic load, 3 swap or compare.
1_1_0000_03_00
2_2_0000_03_00
1_3_0040_07_00
2_4_0040_07_00
1_5_0000_03_20
2_6_0000_03_00
1_7_0040_01_10
2_8_0040_07_00
1_9_0008_00_30
2_9_0000_03_00
1_a_03f8_03_00
2_b_03f8_03_00
2_b_0000_03_00
1_c_0040_05_24
2_c_0040_07_00
1_d_0100_0f_00
2_e_0100_0f_00
1_f_0100_02_1a
2_e_0100_0f_00
1_2_0100_00_31
2_1_0040_07_00

/* project.f */
+incdir+include
hw/atop_pkg.sv
hw/stream_register.sv
hw/atop_write_ctrl.sv
hw/atop_read_inject.sv
hw/axi_burst_mem.sv
hw/atop_filter_top.sv
verification/tb_atop_filter.sv

/* run_sim.sh */
#!/bin/sh
# Builds the atomic-filter testbench with Verilator and runs it from the project root.
# A run that exits with an error status is marked as failed in the log.
verilator --binary --timing --assert -Wno-fatal -f project.f \
  --top-module tb_atop_filter -o sim_atop_filter > build.log 2>&1 \
  || { echo "Verilator build failed, see build.log"; exit 1; }
./obj_dir/sim_atop_filter > sim.log 2>&1 || echo "CHECKS FAILED" >> sim.log
grep -q "CHECKS FAILED" sim.log && { cat sim.log; echo "Simulation failed"; exit 1; }
cat sim.log && echo "Simulation passed"
